/* hdl/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// csr map, FC0h holds the machine id and FC1h the clock in kHz
`define SOC_ID_ADDR 12'hFC0
`define SOC_UART_ADDR 12'hBC0
`define SOC_LED_ADDR 12'hBC1

// identification value returned at FC0h
`define SOC_MACHINE_ID 32'h5256_0132

// board clock and default serial rate
`define SOC_CLOCK_RATE 50_000_000
`define SOC_BAUD_RATE 115_200

// number of led outputs on the board
`define SOC_LED_COUNT 18

// word address width of the 64 KiB memory
`define SOC_MEM_ADDR_BITS 14

`endif

/* hdl/soc_pkg.sv */
package soc_pkg;

    // modify codes follow the csrrw / csrrs / csrrc funct3 encoding
    typedef enum logic [2:0] {
        csr_none  = 3'd0,
        csr_write = 3'd1,
        csr_set   = 3'd2,
        csr_clear = 3'd3
    } csr_op_e;

    typedef logic [11:0] csr_addr_t;

    typedef logic [31:0] word_t;

    // new register value after a csr modify
    function automatic word_t csr_apply(csr_op_e op, word_t old_value, word_t wdata);
        word_t result;
        case (op)
            csr_write: result = wdata;
            csr_set:   result = old_value | wdata;
            csr_clear: result = old_value & ~wdata;
            default:   result = old_value;
        endcase
        return result;
    endfunction

endpackage

/* hdl/csr_ids.sv */
`include "soc_consts.svh"

module csr_ids #(
    parameter int KHZ = `SOC_CLOCK_RATE / 1000
) (
    input  logic              CLOCK_50,
    input  logic              rst,
    input  soc_pkg::csr_addr_t csr_addr,
    output soc_pkg::word_t    rdata,
    output logic              valid
);

    localparam soc_pkg::csr_addr_t ID_ADDR  = `SOC_ID_ADDR;
    localparam soc_pkg::csr_addr_t KHZ_ADDR = `SOC_ID_ADDR + 12'd1;

    logic sel_id;
    logic sel_khz;

    assign sel_id  = (csr_addr == ID_ADDR);
    assign sel_khz = (csr_addr == KHZ_ADDR);

    // both registers are read only constants
    always_comb begin
        rdata = '0;
        if (sel_id) begin
            rdata = `SOC_MACHINE_ID;
        end else if (sel_khz) begin
            rdata = soc_pkg::word_t'(KHZ);
        end
    end

    assign valid = sel_id | sel_khz;

    // software probes both registers and neither may read as zero
    a_id_nonzero: assert property (
        @(posedge CLOCK_50) disable iff (rst)
        valid |-> (rdata != '0)
    );

endmodule

/* hdl/csr_pins_out.sv */
`include "soc_consts.svh"

module csr_pins_out (
    input  logic                      CLOCK_50,
    input  logic                      rst,
    input  logic                      csr_read,
    input  soc_pkg::csr_op_e          csr_modify,
    input  soc_pkg::word_t            csr_wdata,
    input  soc_pkg::csr_addr_t        csr_addr,
    output soc_pkg::word_t            rdata,
    output logic                      valid,
    output logic [`SOC_LED_COUNT-1:0] pins
);

    localparam soc_pkg::word_t PIN_MASK = soc_pkg::word_t'({`SOC_LED_COUNT{1'b1}});

    soc_pkg::word_t pin_q;
    logic           sel;
    logic           access;

    assign sel    = (csr_addr == `SOC_LED_ADDR);
    assign access = sel && (csr_read || csr_modify != soc_pkg::csr_none);

    // write, set and clear act on the full word, then cut to the pin count
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            pin_q <= '0;
        end else if (sel && csr_modify != soc_pkg::csr_none) begin
            pin_q <= soc_pkg::csr_apply(csr_modify, pin_q, csr_wdata) & PIN_MASK;
        end
    end

    assign pins = pin_q[`SOC_LED_COUNT-1:0];

    // readback is zero extended
    assign rdata = access ? pin_q : '0;
    assign valid = access;

    a_upper_zero: assert property (
        @(posedge CLOCK_50) disable iff (rst)
        pin_q[31:`SOC_LED_COUNT] == '0
    );

endmodule

/* hdl/uart_char_regs.sv */
`include "soc_consts.svh"

module uart_char_regs (
    input  logic               CLOCK_50,
    input  logic               rst,
    input  logic               csr_read,
    input  soc_pkg::csr_op_e   csr_modify,
    input  soc_pkg::word_t     csr_wdata,
    input  soc_pkg::csr_addr_t csr_addr,
    input  logic               tx_busy,
    input  logic               rx_strobe,
    input  logic [7:0]         rx_byte,
    output soc_pkg::word_t     rdata,
    output logic               valid,
    output logic               tx_start,
    output logic [7:0]         tx_byte
);

    logic       sel;
    logic       send_req;
    logic       access;
    logic [7:0] rx_data_q;
    logic       rx_valid_q;

    assign sel      = (csr_addr == `SOC_UART_ADDR);
    assign send_req = sel && (csr_modify != soc_pkg::csr_none);
    assign access   = sel && (csr_read || send_req);

    // any modify counts as a send, dropped while the engine is busy
    assign tx_start = send_req && !tx_busy;
    assign tx_byte  = csr_wdata[7:0];

    // a new byte wins over the read that would clear the flag
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            rx_valid_q <= 1'b0;
        end else if (rx_strobe) begin
            rx_valid_q <= 1'b1;
        end else if (sel && csr_read) begin
            rx_valid_q <= 1'b0;
        end
    end

    // overwritten even if the previous byte was never read
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            rx_data_q <= '0;
        end else if (rx_strobe) begin
            rx_data_q <= rx_byte;
        end
    end

    // bit 9 busy, bit 8 rx flag, low byte last character
    always_comb begin
        rdata = '0;
        if (access) begin
            rdata[7:0] = rx_data_q;
            rdata[8]   = rx_valid_q;
            rdata[9]   = tx_busy;
        end
    end

    assign valid = access;

    // the serial engine must accept every start it is given
    a_start_idle: assert property (
        @(posedge CLOCK_50) disable iff (rst)
        tx_start |-> !tx_busy ##1 tx_busy
    );

endmodule

/* hdl/uart_serial.sv */
module uart_serial #(
    parameter int CLOCK_RATE = 50_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic       CLOCK_50,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    input  logic       rx,
    output logic       tx,
    output logic       tx_busy,
    output logic       rx_strobe,
    output logic [7:0] rx_byte
);

    localparam int BIT_CYCLES  = CLOCK_RATE / BAUD_RATE;
    localparam int HALF_CYCLES = BIT_CYCLES / 2;
    localparam int CNT_BITS    = $clog2(BIT_CYCLES);

    localparam logic [CNT_BITS-1:0] BIT_LAST  = CNT_BITS'(BIT_CYCLES - 1);
    localparam logic [CNT_BITS-1:0] HALF_LAST = CNT_BITS'(HALF_CYCLES - 1);

    logic [CNT_BITS-1:0] tx_cnt;
    logic [3:0]          tx_bits;
    logic [8:0]          tx_shift;

    logic                rx_meta;
    logic                rx_in;
    logic                rx_prev;
    logic                rx_active;
    logic [CNT_BITS-1:0] rx_cnt;
    logic [3:0]          rx_bits;
    logic [7:0]          rx_shift;

    // transmit, start bit goes out on the edge that sees tx_start
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            tx_cnt  <= '0;
            tx_bits <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx       <= 1'b0;
                tx_busy  <= 1'b1;
                tx_shift <= {1'b1, tx_byte};
                tx_cnt   <= BIT_LAST;
                tx_bits  <= '0;
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 1'b1;
        end else if (tx_bits == 4'd9) begin
            // end of stop bit
            tx_busy <= 1'b0;
        end else begin
            tx       <= tx_shift[0];
            tx_shift <= {1'b1, tx_shift[8:1]};
            tx_cnt   <= BIT_LAST;
            tx_bits  <= tx_bits + 1'b1;
        end
    end

    // two stage synchronizer plus the previous sample for edge detect
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_in   <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_in   <= rx_meta;
            rx_prev <= rx_in;
        end
    end

    // receive, samples taken in the middle of each bit
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            rx_active <= 1'b0;
            rx_strobe <= 1'b0;
            rx_cnt    <= '0;
            rx_bits   <= '0;
        end else begin
            rx_strobe <= 1'b0;
            if (!rx_active) begin
                if (rx_prev && !rx_in) begin
                    rx_active <= 1'b1;
                    rx_cnt    <= HALF_LAST;
                    rx_bits   <= '0;
                end
            end else if (rx_cnt != '0) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                rx_cnt  <= BIT_LAST;
                rx_bits <= rx_bits + 1'b1;
                if (rx_bits == 4'd0 && rx_in) begin
                    // glitch, not a real start bit
                    rx_active <= 1'b0;
                end else if (rx_bits == 4'd9) begin
                    rx_active <= 1'b0;
                    rx_strobe <= rx_in;
                end else if (rx_bits != 4'd0) begin
                    rx_shift <= {rx_in, rx_shift[7:1]};
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rx_active && rx_cnt == '0 && rx_bits == 4'd9 && rx_in) begin
            rx_byte <= rx_shift;
        end
    end

    a_strobe_single: assert property (
        @(posedge CLOCK_50) disable iff (rst)
        rx_strobe |=> !rx_strobe
    );

endmodule

/* hdl/bram_memory.sv */
`include "soc_consts.svh"

module bram_memory (
    input  logic                         CLOCK_50,
    input  logic                         write,
    input  logic [3:0]                   wmask,
    input  soc_pkg::word_t               wdata,
    input  logic [`SOC_MEM_ADDR_BITS-1:0] addr,
    output soc_pkg::word_t               rdata
);

    localparam int DEPTH = 1 << `SOC_MEM_ADDR_BITS;

    // one byte wide array per lane so each maps to its own block ram
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        logic [7:0] mem [DEPTH];
        logic [7:0] rd_q;

        // read first, a write in the same cycle returns old content
        always_ff @(posedge CLOCK_50) begin
            rd_q <= mem[addr];
            if (write && wmask[lane]) begin
                mem[addr] <= wdata[8*lane +: 8];
            end
        end

        assign rdata[8*lane +: 8] = rd_q;
    end

    a_addr_known: assert property (
        @(posedge CLOCK_50)
        write |-> !$isunknown(addr)
    );

endmodule

/* hdl/soc_top.sv */
`include "soc_consts.svh"

module soc_top #(
    parameter int CLOCK_RATE = `SOC_CLOCK_RATE,
    parameter int BAUD_RATE  = `SOC_BAUD_RATE
) (
    input  logic                      CLOCK_50,
    input  logic                      rst,
    input  logic                      csr_read,
    input  soc_pkg::csr_op_e          csr_modify,
    input  soc_pkg::word_t            csr_wdata,
    input  soc_pkg::csr_addr_t        csr_addr,
    output soc_pkg::word_t            csr_rdata,
    output logic                      csr_valid,
    input  logic                      mem_write,
    input  logic [3:0]                mem_wmask,
    input  soc_pkg::word_t            mem_wdata,
    input  soc_pkg::word_t            mem_addr,
    output soc_pkg::word_t            mem_rdata,
    input  logic                      UART_RXD,
    output logic                      UART_TXD,
    output logic [`SOC_LED_COUNT-1:0] LEDR
);

    soc_pkg::word_t ids_rdata;
    logic           ids_valid;
    soc_pkg::word_t led_rdata;
    logic           led_valid;
    soc_pkg::word_t uart_rdata;
    logic           uart_valid;

    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       rx_strobe;
    logic [7:0] rx_byte;

    csr_ids #(
        .KHZ(CLOCK_RATE / 1000)
    ) u_ids (
        .CLOCK_50 (CLOCK_50),
        .rst      (rst),
        .csr_addr (csr_addr),
        .rdata    (ids_rdata),
        .valid    (ids_valid)
    );

    csr_pins_out u_leds (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .csr_read   (csr_read),
        .csr_modify (csr_modify),
        .csr_wdata  (csr_wdata),
        .csr_addr   (csr_addr),
        .rdata      (led_rdata),
        .valid      (led_valid),
        .pins       (LEDR)
    );

    uart_char_regs u_uart_regs (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .csr_read   (csr_read),
        .csr_modify (csr_modify),
        .csr_wdata  (csr_wdata),
        .csr_addr   (csr_addr),
        .tx_busy    (tx_busy),
        .rx_strobe  (rx_strobe),
        .rx_byte    (rx_byte),
        .rdata      (uart_rdata),
        .valid      (uart_valid),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte)
    );

    uart_serial #(
        .CLOCK_RATE (CLOCK_RATE),
        .BAUD_RATE  (BAUD_RATE)
    ) u_uart_serial (
        .CLOCK_50  (CLOCK_50),
        .rst       (rst),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .rx        (UART_RXD),
        .tx        (UART_TXD),
        .tx_busy   (tx_busy),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte)
    );

    // unselected blocks drive zero, so a plain OR combines them
    assign csr_rdata = ids_rdata | led_rdata | uart_rdata;
    assign csr_valid = ids_valid | led_valid | uart_valid;

    // byte address in, word address to the ram
    bram_memory u_mem (
        .CLOCK_50 (CLOCK_50),
        .write    (mem_write),
        .wmask    (mem_wmask),
        .wdata    (mem_wdata),
        .addr     (mem_addr[`SOC_MEM_ADDR_BITS+1:2]),
        .rdata    (mem_rdata)
    );

endmodule

/* bench/tb_soc_top.sv */
`include "soc_consts.svh"

module tb_soc_top;

    localparam int LED_ENTRIES   = 12;
    localparam int MEM_ENTRIES   = 16;
    localparam int NUM_ENTRIES   = LED_ENTRIES + MEM_ENTRIES;
    localparam int MEM_ZERO_MASK = 12;
    localparam int UART_WAIT     = 200;

    localparam soc_pkg::word_t LED_MASK = (32'h1 << `SOC_LED_COUNT) - 1;

    typedef struct packed {
        logic               is_mem;
        soc_pkg::csr_op_e   op;
        soc_pkg::word_t     addr;
        soc_pkg::word_t     wdata;
        logic [3:0]         mask;
        soc_pkg::word_t     expected;
    } entry_t;

    logic                      CLOCK_50 = 1'b0;
    logic                      rst;
    logic                      csr_read;
    soc_pkg::csr_op_e          csr_modify;
    soc_pkg::word_t            csr_wdata;
    soc_pkg::csr_addr_t        csr_addr;
    soc_pkg::word_t            csr_rdata;
    logic                      csr_valid;
    logic                      mem_write;
    logic [3:0]                mem_wmask;
    soc_pkg::word_t            mem_wdata;
    soc_pkg::word_t            mem_addr;
    soc_pkg::word_t            mem_rdata;
    logic                      UART_RXD;
    logic                      UART_TXD;
    logic [`SOC_LED_COUNT-1:0] LEDR;

    entry_t         entries [NUM_ENTRIES];
    soc_pkg::word_t mem_model [1 << `SOC_MEM_ADDR_BITS];
    logic [31:0]    lfsr_state = 32'h877c;
    int             error_count = 0;
    int             tests_passed = 0;
    int             tests_failed = 0;

    // 10 cycles per bit on the serial link
    soc_top #(
        .BAUD_RATE(5_000_000)
    ) DUT (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .csr_read   (csr_read),
        .csr_modify (csr_modify),
        .csr_wdata  (csr_wdata),
        .csr_addr   (csr_addr),
        .csr_rdata  (csr_rdata),
        .csr_valid  (csr_valid),
        .mem_write  (mem_write),
        .mem_wmask  (mem_wmask),
        .mem_wdata  (mem_wdata),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .UART_RXD   (UART_RXD),
        .UART_TXD   (UART_TXD),
        .LEDR       (LEDR)
    );

    // serial loopback
    assign UART_RXD = UART_TXD;

    always #20 CLOCK_50 = ~CLOCK_50;

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic take_bits(input int count, output soc_pkg::word_t value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic compare_word(input string name, input soc_pkg::word_t expected,
                                input soc_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("Mismatch at time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // one bus cycle with outputs looked at on the falling edge
    task automatic drive_csr(input logic read, input soc_pkg::csr_op_e op,
                             input soc_pkg::csr_addr_t addr, input soc_pkg::word_t wdata);
        @(posedge CLOCK_50);
        csr_read   <= read;
        csr_modify <= op;
        csr_addr   <= addr;
        csr_wdata  <= wdata;
        @(negedge CLOCK_50);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // expected values come from the led shadow and the memory model
    task automatic build_table();
        soc_pkg::word_t   led_shadow;
        soc_pkg::word_t   r;
        soc_pkg::word_t   wdata;
        logic [13:0]      pool [8];
        logic [13:0]      word_index;
        logic [3:0]       mask;
        soc_pkg::csr_op_e op;
        led_shadow = '0;
        for (int i = 0; i < LED_ENTRIES; i++) begin
            take_bits(2, r);
            op = soc_pkg::csr_op_e'({1'b0, r[1:0]});
            if (i == 0) begin
                op = soc_pkg::csr_write;
            end
            take_bits(32, wdata);
            // write replaces, set ors in, clear removes the given bits
            case (op)
                soc_pkg::csr_write: led_shadow = wdata & LED_MASK;
                soc_pkg::csr_set:   led_shadow = (led_shadow | wdata) & LED_MASK;
                soc_pkg::csr_clear: led_shadow = led_shadow & ~wdata;
                default:            led_shadow = led_shadow;
            endcase
            entries[i].is_mem   = 1'b0;
            entries[i].op       = op;
            entries[i].addr     = `SOC_LED_ADDR;
            entries[i].wdata    = wdata;
            entries[i].mask     = '0;
            entries[i].expected = led_shadow;
        end
        // the first eight writes fill whole words and later ones hit them with masks
        for (int i = 0; i < MEM_ENTRIES; i++) begin
            if (i < 8) begin
                take_bits(14, r);
                pool[i]    = r[13:0];
                word_index = pool[i];
                mask       = 4'hf;
            end else begin
                take_bits(3, r);
                word_index = pool[r[2:0]];
                take_bits(4, r);
                mask = r[3:0];
            end
            if (i == MEM_ZERO_MASK) begin
                mask = 4'h0;
            end
            take_bits(32, wdata);
            for (int lane = 0; lane < 4; lane++) begin
                if (mask[lane]) begin
                    mem_model[word_index][8*lane +: 8] = wdata[8*lane +: 8];
                end
            end
            entries[LED_ENTRIES + i].is_mem   = 1'b1;
            entries[LED_ENTRIES + i].op       = soc_pkg::csr_none;
            entries[LED_ENTRIES + i].addr     = soc_pkg::word_t'({word_index, 2'b00});
            entries[LED_ENTRIES + i].wdata    = wdata;
            entries[LED_ENTRIES + i].mask     = mask;
            entries[LED_ENTRIES + i].expected = mem_model[word_index];
        end
    endtask

    task automatic apply_led_entry(input entry_t e);
        drive_csr(1'b0, e.op, e.addr[11:0], e.wdata);
        drive_csr(1'b1, soc_pkg::csr_none, e.addr[11:0], '0);
        compare_word("LEDR", e.expected, soc_pkg::word_t'(LEDR));
        compare_word("led readback", e.expected, csr_rdata);
        compare_word("led csr_valid", 32'd1, soc_pkg::word_t'(csr_valid));
    endtask

    // write and then read the same word with data one cycle behind the address
    task automatic apply_mem_entry(input entry_t e);
        @(posedge CLOCK_50);
        mem_write <= 1'b1;
        mem_wmask <= e.mask;
        mem_wdata <= e.wdata;
        mem_addr  <= e.addr;
        @(posedge CLOCK_50);
        mem_write <= 1'b0;
        mem_wmask <= 4'h0;
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        compare_word("mem_rdata", e.expected, mem_rdata);
    endtask

    task automatic run_entries(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (entries[i].is_mem) begin
                apply_mem_entry(entries[i]);
            end else begin
                apply_led_entry(entries[i]);
            end
        end
    endtask

    task automatic run_id_test();
        soc_pkg::word_t led_before;
        led_before = soc_pkg::word_t'(LEDR);
        drive_csr(1'b1, soc_pkg::csr_none, `SOC_ID_ADDR, '0);
        compare_word("id csr_valid", 32'd1, soc_pkg::word_t'(csr_valid));
        compare_word("machine id", `SOC_MACHINE_ID, csr_rdata);
        drive_csr(1'b1, soc_pkg::csr_none, `SOC_ID_ADDR + 12'd1, '0);
        compare_word("khz csr_valid", 32'd1, soc_pkg::word_t'(csr_valid));
        compare_word("clock khz", 32'd50_000, csr_rdata);
        drive_csr(1'b1, soc_pkg::csr_none, `SOC_LED_ADDR, '0);
        drive_csr(1'b0, soc_pkg::csr_none, 12'h000, '0);
        compare_word("LEDR after reads", led_before, soc_pkg::word_t'(LEDR));
    endtask

    task automatic run_uart_test();
        soc_pkg::word_t r;
        logic [7:0]     first_byte;
        logic           seen;
        logic           extra;
        int             waited;
        take_bits(8, r);
        first_byte = r[7:0];
        drive_csr(1'b0, soc_pkg::csr_write, `SOC_UART_ADDR, {24'h0, first_byte});
        drive_csr(1'b1, soc_pkg::csr_none, `SOC_UART_ADDR, '0);
        compare_word("uart tx_busy", 32'd1, soc_pkg::word_t'(csr_rdata[9]));
        // the engine is busy so this send must be dropped
        drive_csr(1'b0, soc_pkg::csr_write, `SOC_UART_ADDR, {24'h0, ~first_byte});
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < UART_WAIT) begin
            drive_csr(1'b1, soc_pkg::csr_none, `SOC_UART_ADDR, '0);
            seen = csr_rdata[8];
            waited++;
        end
        assert (seen) else begin
            $display("uart receive wait timed out after %0d cycles", waited);
            error_count++;
        end
        if (seen) begin
            compare_word("uart rx byte", {24'h0, first_byte}, {24'h0, csr_rdata[7:0]});
            drive_csr(1'b1, soc_pkg::csr_none, `SOC_UART_ADDR, '0);
            compare_word("uart rx_valid after read", 32'd0, soc_pkg::word_t'(csr_rdata[8]));
        end
        waited = 0;
        while (csr_rdata[9] && waited < UART_WAIT) begin
            drive_csr(1'b1, soc_pkg::csr_none, `SOC_UART_ADDR, '0);
            waited++;
        end
        assert (!csr_rdata[9]) else begin
            $display("uart transmitter idle wait timed out after %0d cycles", waited);
            error_count++;
        end
        // line must stay quiet with nothing received
        extra = 1'b0;
        for (int i = 0; i < 120; i++) begin
            drive_csr(1'b1, soc_pkg::csr_none, `SOC_UART_ADDR, '0);
            extra = extra | csr_rdata[8] | csr_rdata[9];
        end
        assert (!extra) else begin
            $display("second uart send while busy was not dropped");
            error_count++;
        end
        drive_csr(1'b0, soc_pkg::csr_none, 12'h000, '0);
    endtask

    initial begin
        int errors_before;
        rst        = 1'b1;
        csr_read   = 1'b0;
        csr_modify = soc_pkg::csr_none;
        csr_wdata  = '0;
        csr_addr   = '0;
        mem_write  = 1'b0;
        mem_wmask  = 4'h0;
        mem_wdata  = '0;
        mem_addr   = '0;
        build_table();
        repeat (4) @(posedge CLOCK_50);
        rst <= 1'b0;

        errors_before = error_count;
        @(negedge CLOCK_50);
        compare_word("LEDR after reset", 32'd0, soc_pkg::word_t'(LEDR));
        compare_word("UART_TXD after reset", 32'd1, soc_pkg::word_t'(UART_TXD));
        drive_csr(1'b1, soc_pkg::csr_none, 12'h123, '0);
        compare_word("unmapped csr_valid", 32'd0, soc_pkg::word_t'(csr_valid));
        compare_word("unmapped csr_rdata", 32'd0, csr_rdata);
        finish_test("reset", errors_before);

        errors_before = error_count;
        run_entries(0, LED_ENTRIES - 1);
        finish_test("led register", errors_before);

        errors_before = error_count;
        run_id_test();
        finish_test("identification", errors_before);

        errors_before = error_count;
        run_entries(LED_ENTRIES, NUM_ENTRIES - 1);
        finish_test("memory", errors_before);

        errors_before = error_count;
        run_uart_test();
        finish_test("uart loopback", errors_before);

        $display("tests passed %0d failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/csr_ids.sv
hdl/csr_pins_out.sv
hdl/uart_char_regs.sv
hdl/uart_serial.sv
hdl/bram_memory.sv
hdl/soc_top.sv
bench/tb_soc_top.sv
